// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_ql_bus
FILELIST  = compile.f

SRCS := $(wildcard *.sv)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf obj_dir

// ==== compile.f ====
ql_bus_pkg.sv
ql_clock_reset.sv
ql_address_decode.sv
ql_config_regs.sv
ql_rom_store.sv
ql_data_steer.sv
ql_bus_top.sv
ql_bus_properties.sv
tb_clock_gen.sv
tb_ql_bus.sv

// ==== ql_address_decode.sv ====
//========================================
// QL and GoldCard memory map decode
// Builds the byte address, wraps it by RAM
// size and flags the region it falls in
//========================================

`timescale 1ns/100ps

module ql_address_decode (
	input  ql_bus_pkg::cpu_req_t   cpu_req,
	input  ql_bus_pkg::ram_cfg_t   ram_cfg,
	output ql_bus_pkg::ql_addr_t   cpu_addr,
	output ql_bus_pkg::ql_region_t region
);

	ql_bus_pkg::ql_addr_t addr_mask;
	logic lds_only;     // Odd byte access
	logic gc_en;
	logic bram;         // Base RAM
	logic xram;         // Extended RAM for the configured size
	logic gc_ram1;
	logic gc_ram2;
	logic gc_io;

	assign gc_en    = (ram_cfg == ql_bus_pkg::RAM_4096K);
	assign lds_only = !cpu_req.uds && cpu_req.lds;

	// ========================================
	// Address wrap
	// ========================================
	always_comb begin
		case (ram_cfg)
			ql_bus_pkg::RAM_128K: addr_mask = 24'h03ffff;   // 256k space
			ql_bus_pkg::RAM_640K,
			ql_bus_pkg::RAM_896K: addr_mask = 24'h0fffff;   // 1M space
			default:              addr_mask = 24'h7fffff;   // 8M space
		endcase
	end

	assign cpu_addr = {cpu_req.waddr, lds_only} & addr_mask;

	// ========================================
	// Region flags
	// ========================================
	assign bram = (cpu_addr[23:17] == 7'h01);   // 20000-3ffff

	always_comb begin
		case (ram_cfg)
			ql_bus_pkg::RAM_640K:                          // 40000-bffff
				xram = (cpu_addr[23:20] == 4'h0) && ^cpu_addr[19:18];
			ql_bus_pkg::RAM_896K:                          // 40000-fffff
				xram = (cpu_addr[23:20] == 4'h0) && |cpu_addr[19:18];
			ql_bus_pkg::RAM_4096K:                         // 40000-3fffff
				xram = (cpu_addr[23:22] == 2'h0) && |cpu_addr[21:18];
			default:
				xram = 1'b0;                               // Base RAM only
		endcase
	end

	// GoldCard extras
	assign gc_io   = gc_en && (cpu_addr[23:8] == 16'h01c0);            // 1c000-1c0ff
	assign gc_ram1 = gc_en && (cpu_addr[23:15] == 9'h002);             // 10000-17fff
	assign gc_ram2 = gc_en && (cpu_addr[23:14] == 10'h007) && !gc_io;  // 1c100-1ffff

	always_comb begin
		region             = '0;
		region.rom         = (cpu_addr[23:16] == 8'h00);
		region.ext_rom     = (cpu_addr[23:14] == 10'h003);
		region.os_rom      = region.rom && !region.ext_rom;
		region.ql_io       = (cpu_addr[23:14] == 10'h006);   // 18000-1bfff
		region.ram         = bram || xram || gc_ram1 || gc_ram2;
		region.gc_io       = gc_io;
		region.gc_boot_rom = gc_en && (cpu_addr[23:16] == 8'h04);
		region.gc_os_rom   = gc_en && (cpu_addr[23:16] == 8'h40);
		region.gc_en       = gc_en;
		// Strobes qualify both directions
		region.rd = cpu_req.as && cpu_req.rw && (cpu_req.uds || cpu_req.lds);
		region.wr = cpu_req.as && !cpu_req.rw && (cpu_req.uds || cpu_req.lds);
	end

endmodule

// ==== ql_bus_pkg.sv ====
//========================================
// QL bus fabric shared definitions
// Widths, bus structs, speed codes and the
// GoldCard register offsets
//========================================

package ql_bus_pkg;

	// ========================================
	// Widths
	// ========================================
	typedef logic [23:0] ql_addr_t;    // Byte address
	typedef logic [15:0] ql_word_t;    // Data word
	typedef logic [22:0] ql_waddr_t;   // Word address as driven by the CPU
	typedef logic [1:0]  ram_cfg_t;    // RAM size code
	typedef logic [3:0]  bus_div_t;    // Bus divider count

	localparam int ROM_AW = 15;        // 32k words per ROM

	// RAM size codes
	localparam ram_cfg_t RAM_128K  = 2'd0;
	localparam ram_cfg_t RAM_640K  = 2'd1;
	localparam ram_cfg_t RAM_896K  = 2'd2;
	localparam ram_cfg_t RAM_4096K = 2'd3;  // Also GoldCard mode

	// CPU speed selection
	typedef enum logic [1:0] {
		QL   = 2'd0,   // Original QL bus
		GC16 = 2'd1,   // GoldCard 16 MHz
		GC24 = 2'd2,   // GoldCard 24 MHz
		FULL = 2'd3    // As fast as the system clock allows
	} cpu_speed_t;

	// System clock cycles per bus cycle
	localparam bus_div_t DIV_QL   = 4'd11;
	localparam bus_div_t DIV_16   = 4'd5;
	localparam bus_div_t DIV_24   = 4'd3;
	localparam bus_div_t DIV_FULL = 4'd2;

	// GoldCard shadow control, low address byte
	localparam logic [7:0] SHADOW_ON_REG  = 8'h60;
	localparam logic [7:0] SHADOW_OFF_REG = 8'h64;

	// ========================================
	// Bus structs
	// ========================================
	typedef struct packed {
		ql_waddr_t waddr;
		logic      rw;      // 1 = read
		logic      uds;
		logic      lds;
		logic      as;
		ql_word_t  wdata;
	} cpu_req_t;

	typedef struct packed {
		ql_waddr_t waddr;
		ql_word_t  wdata;
		logic      we;
		logic      oe;
		logic      uds;
		logic      lds;
	} ram_req_t;

	typedef struct packed {
		logic rom;          // 0000-ffff
		logic ext_rom;      // c000-ffff
		logic os_rom;       // 0000-bfff
		logic ql_io;        // Internal I/O
		logic ram;          // Any RAM
		logic gc_io;        // GoldCard I/O page
		logic gc_boot_rom;  // Boot ROM copy
		logic gc_os_rom;    // OS ROM copy
		logic gc_en;
		logic rd;
		logic wr;
	} ql_region_t;

endpackage

// ==== ql_bus_properties.sv ====
//========================================
// Bus protocol assertions
// Bound to the bus fabric top level
//========================================

`timescale 1ns/100ps

module ql_bus_properties (
	input logic                 clk_sys,
	input logic                 core_reset,
	input ql_bus_pkg::cpu_req_t cpu_req,
	input logic                 cpu_dtack,
	input ql_bus_pkg::ram_req_t ram_req
);

	// Master holds the request until acknowledged
	req_stable: assert property (@(posedge clk_sys) disable iff (core_reset)
		cpu_req.as && !cpu_dtack |=> $stable(cpu_req))
		else $error("cpu_req changed before cpu_dtack");

	rw_exclusive: assert property (@(posedge clk_sys)
		!(ram_req.we && ram_req.oe))
		else $error("ram_req we and oe high together");

	// No RAM traffic while the core is held
	idle_in_reset: assert property (@(posedge clk_sys)
		core_reset |-> !ram_req.we && !ram_req.oe)
		else $error("ram_req active during core_reset");

endmodule

bind ql_bus_top ql_bus_properties i_bus_properties (
	.clk_sys(clk_sys), .core_reset(core_reset), .cpu_req(cpu_req),
	.cpu_dtack(cpu_dtack), .ram_req(ram_req)
);

// ==== ql_bus_top.sv ====
//========================================
// QL CPU bus fabric top level
// Clocking, decode, ROMs and data steering
//========================================

`timescale 1ns/100ps

module ql_bus_top #(
	parameter int RESET_HOLD = 4095
) (
	input  logic                              reset,
	input  logic                              clk_sys,
	input  ql_bus_pkg::cpu_speed_t            cpu_speed,
	input  ql_bus_pkg::ram_cfg_t              ram_cfg_sel,
	input  logic                              dl_active,
	input  logic                              dl_index,    // 0 OS ROM, 1 boot ROM
	input  logic                              dl_wr,
	input  logic [ql_bus_pkg::ROM_AW-1:0]     dl_addr,
	input  ql_bus_pkg::ql_word_t              dl_data,
	input  ql_bus_pkg::cpu_req_t              cpu_req,
	input  ql_bus_pkg::ql_word_t              ram_rdata,
	input  logic                              ram_ack,
	output logic                              ce_bus_p,
	output logic                              ce_bus_n,
	output logic                              core_reset,
	output ql_bus_pkg::ql_word_t              cpu_rdata,
	output logic                              cpu_dtack,
	output ql_bus_pkg::ram_req_t              ram_req
);

	ql_bus_pkg::ql_addr_t   cpu_addr;
	ql_bus_pkg::ql_region_t region;
	ql_bus_pkg::ram_cfg_t   ram_cfg;
	ql_bus_pkg::cpu_req_t   wrap_req;      // Request with wrapped address
	ql_bus_pkg::ql_word_t   os_rom_data;
	ql_bus_pkg::ql_word_t   boot_rom_data;
	logic rom_shadow;
	logic os_rom_we;
	logic boot_rom_we;

	assign os_rom_we   = dl_wr && !dl_index;
	assign boot_rom_we = dl_wr && dl_index;

	always_comb begin
		wrap_req       = cpu_req;
		wrap_req.waddr = cpu_addr[23:1];
	end

	ql_clock_reset #(.RESET_HOLD(RESET_HOLD)) i_clock_reset (
		.clk_sys, .reset, .dl_active, .cpu_speed,
		.ce_bus_p, .ce_bus_n, .core_reset
	);

	ql_config_regs i_config_regs (
		.clk_sys, .core_reset, .ram_cfg_sel, .cpu_req(wrap_req),
		.region, .ram_cfg, .rom_shadow
	);

	ql_address_decode i_address_decode (
		.cpu_req, .ram_cfg, .cpu_addr, .region
	);

	// ========================================
	// ROM stores
	// ========================================
	ql_rom_store #(.ADDR_W(ql_bus_pkg::ROM_AW)) os_rom (
		.clk_sys, .wr_en(os_rom_we), .wr_addr(dl_addr), .wr_data(dl_data),
		.rd_addr(cpu_addr[15:1]), .rd_data(os_rom_data)
	);

	ql_rom_store #(.ADDR_W(ql_bus_pkg::ROM_AW)) boot_rom (
		.clk_sys, .wr_en(boot_rom_we), .wr_addr(dl_addr), .wr_data(dl_data),
		.rd_addr(cpu_addr[15:1]), .rd_data(boot_rom_data)
	);

	ql_data_steer i_data_steer (
		.clk_sys, .core_reset, .cpu_req(wrap_req), .region, .rom_shadow,
		.os_rom_data, .boot_rom_data, .ram_rdata, .ram_ack,
		.ram_req, .cpu_rdata, .cpu_dtack
	);

endmodule

// ==== ql_clock_reset.sv ====
//========================================
// Bus clock enables and core reset
// Divides clk_sys down to the selected CPU
// speed and stretches the core reset
//========================================

`timescale 1ns/100ps

module ql_clock_reset #(
	parameter int RESET_HOLD = 4095
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   dl_active,
	input  ql_bus_pkg::cpu_speed_t cpu_speed,
	output logic                   ce_bus_p,
	output logic                   ce_bus_n,
	output logic                   core_reset
);

	localparam int HOLD_W = $clog2(RESET_HOLD + 1);

	ql_bus_pkg::bus_div_t div_cnt;
	ql_bus_pkg::bus_div_t div_len;    // Cycles per bus cycle
	logic [HOLD_W-1:0]    hold_cnt;   // Remaining ce_bus_p pulses

	// ========================================
	// Bus divider
	// ========================================
	always_comb begin
		case (cpu_speed)
			ql_bus_pkg::QL:   div_len = ql_bus_pkg::DIV_QL;
			ql_bus_pkg::GC16: div_len = ql_bus_pkg::DIV_16;
			ql_bus_pkg::GC24: div_len = ql_bus_pkg::DIV_24;
			default:          div_len = ql_bus_pkg::DIV_FULL;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div_cnt  <= '0;
			ce_bus_p <= 1'b0;
			ce_bus_n <= 1'b0;
		end else begin
			// Greater-or-equal catches a speed change to a shorter count
			if (div_cnt >= div_len - 4'd1)
				div_cnt <= '0;
			else
				div_cnt <= div_cnt + 4'd1;
			ce_bus_p <= (div_cnt == '0);
			ce_bus_n <= (div_cnt == (div_len >> 1));  // Half a bus cycle later
		end
	end

	// ========================================
	// Reset stretcher
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset || dl_active)
			hold_cnt <= HOLD_W'(RESET_HOLD);   // Reload while held
		else if (ce_bus_p && hold_cnt != '0)
			hold_cnt <= hold_cnt - 1'b1;
	end

	assign core_reset = (hold_cnt != '0);

endmodule

// ==== ql_config_regs.sv ====
//========================================
// RAM size latch and GoldCard shadow bit
//========================================

`timescale 1ns/100ps

module ql_config_regs (
	input  logic                   clk_sys,
	input  logic                   core_reset,
	input  ql_bus_pkg::ram_cfg_t   ram_cfg_sel,
	input  ql_bus_pkg::cpu_req_t   cpu_req,
	input  ql_bus_pkg::ql_region_t region,
	output ql_bus_pkg::ram_cfg_t   ram_cfg,
	output logic                   rom_shadow
);

	logic [7:0] reg_sel;   // Low address byte
	logic       reg_wr;

	// Upper byte writes only, so address bit 0 is always clear
	assign reg_sel = {cpu_req.waddr[6:0], 1'b0};
	assign reg_wr  = region.gc_io && region.wr && cpu_req.uds && !cpu_req.lds;

	// Size only changes while the core is held
	always_ff @(posedge clk_sys) begin
		if (core_reset)
			ram_cfg <= ram_cfg_sel;
	end

	always_ff @(posedge clk_sys) begin
		if (core_reset) begin
			rom_shadow <= 1'b0;
		end else if (reg_wr) begin
			if (reg_sel == ql_bus_pkg::SHADOW_ON_REG)
				rom_shadow <= 1'b1;      // ROM area reads from RAM
			else if (reg_sel == ql_bus_pkg::SHADOW_OFF_REG)
				rom_shadow <= 1'b0;      // Back to boot mapping
		end
	end

endmodule

// ==== ql_data_steer.sv ====
//========================================
// RAM request and CPU read data steering
// Picks read data and acknowledge by map,
// mode and shadow state
//========================================

`timescale 1ns/100ps

module ql_data_steer (
	input  logic                   clk_sys,
	input  logic                   core_reset,
	input  ql_bus_pkg::cpu_req_t   cpu_req,
	input  ql_bus_pkg::ql_region_t region,
	input  logic                   rom_shadow,
	input  ql_bus_pkg::ql_word_t   os_rom_data,
	input  ql_bus_pkg::ql_word_t   boot_rom_data,
	input  ql_bus_pkg::ql_word_t   ram_rdata,
	input  logic                   ram_ack,
	output ql_bus_pkg::ram_req_t   ram_req,
	output ql_bus_pkg::ql_word_t   cpu_rdata,
	output logic                   cpu_dtack
);

	logic shadow_rd;   // OS ROM read served by RAM
	logic shadow_wr;   // OS ROM write lands in RAM
	logic ram_rd;
	logic ram_wr;
	logic rom_rd;      // Read served by a ROM store
	logic rom_wait;
	ql_bus_pkg::ql_word_t ql_dout;
	ql_bus_pkg::ql_word_t gc_boot_dout;
	ql_bus_pkg::ql_word_t gc_shadow_dout;

	// ========================================
	// RAM request
	// ========================================
	assign shadow_rd = region.rd && region.os_rom && rom_shadow;
	assign shadow_wr = region.wr && region.os_rom && !rom_shadow;
	assign ram_rd    = (region.rd && region.ram) || shadow_rd;
	assign ram_wr    = (region.wr && region.ram) || shadow_wr;

	always_comb begin
		ram_req.waddr = cpu_req.waddr;
		ram_req.wdata = cpu_req.wdata;
		ram_req.we    = ram_wr;
		ram_req.oe    = ram_rd;
		ram_req.uds   = cpu_req.uds;
		ram_req.lds   = cpu_req.lds;
	end

	// ========================================
	// Read data
	// ========================================
	assign ql_dout = region.rom ? os_rom_data :
	                 region.ram ? ram_rdata : 16'hffff;

	assign gc_boot_dout = region.rom         ? boot_rom_data :
	                      region.gc_boot_rom ? boot_rom_data :   // 40000 copy
	                      region.gc_os_rom   ? os_rom_data :
	                      region.ram         ? ram_rdata : 16'hffff;

	assign gc_shadow_dout = region.os_rom    ? ram_rdata :       // Shadow RAM
	                        region.ext_rom   ? os_rom_data :
	                        region.gc_os_rom ? os_rom_data :
	                        region.ram       ? ram_rdata : 16'hffff;

	always_comb begin
		if (region.ql_io)
			cpu_rdata = '0;        // Nothing left behind internal I/O
		else if (region.gc_en)
			cpu_rdata = rom_shadow ? gc_shadow_dout : gc_boot_dout;
		else
			cpu_rdata = ql_dout;
	end

	// ========================================
	// Acknowledge
	// ========================================
	assign rom_rd = region.rd && (region.rom || region.gc_os_rom) && !ram_rd;

	// One wait cycle for the registered ROM read
	always_ff @(posedge clk_sys) begin
		if (core_reset)
			rom_wait <= 1'b0;
		else
			rom_wait <= rom_rd && !rom_wait;
	end

	always_comb begin
		if (ram_rd || ram_wr)
			cpu_dtack = ram_ack;   // RAM sets the pace
		else if (rom_rd)
			cpu_dtack = rom_wait;
		else
			cpu_dtack = cpu_req.as;
	end

endmodule

// ==== ql_rom_store.sv ====
//========================================
// Downloadable word ROM
// Written from the download port, read
// with one cycle of latency
//========================================

`timescale 1ns/100ps

module ql_rom_store #(
	parameter int ADDR_W = 15
) (
	input  logic                 clk_sys,
	input  logic                 wr_en,
	input  logic [ADDR_W-1:0]    wr_addr,
	input  ql_bus_pkg::ql_word_t wr_data,
	input  logic [ADDR_W-1:0]    rd_addr,
	output ql_bus_pkg::ql_word_t rd_data
);

	ql_bus_pkg::ql_word_t mem [2**ADDR_W];
	ql_bus_pkg::ql_word_t wr_word;

	// Download sends the high byte last
	assign wr_word = {wr_data[7:0], wr_data[15:8]};

	always_ff @(posedge clk_sys) begin
		if (wr_en)
			mem[wr_addr] <= wr_word;
	end

	// Registered read
	always_ff @(posedge clk_sys) begin
		rd_data <= mem[rd_addr];
	end

endmodule

// ==== tb_clock_gen.sv ====
//========================================
// Testbench clock source
//========================================

`timescale 1ns/100ps

module tb_clock_gen #(
	parameter realtime PERIOD_NS = 8.0
) (
	output logic clk
);

	initial clk = 1'b0;

	always #(PERIOD_NS / 2.0) clk = ~clk;   // Free running

endmodule

// ==== tb_ql_bus.sv ====
//========================================
// QL bus fabric testbench
// Random bus master, RAM model and memory
// map reference model
//========================================

`timescale 1ns/100ps

module tb_ql_bus;

	localparam int RESET_HOLD   = 16;
	localparam int NUM_RAND     = 250;   // Per RAM size
	localparam int NUM_DIRECTED = 16;
	localparam int ROM_WORDS    = 32768;
	localparam int DL_CYCLES    = 2 * ROM_WORDS;
	localparam int TIMEOUT_CYC  = (4 * NUM_RAND + NUM_DIRECTED) * 40 + DL_CYCLES
		+ 5 * (RESET_HOLD * 12 + 16) + 400;

	logic clk_sys;
	logic reset;
	logic dl_active;
	logic dl_index;
	logic dl_wr;
	logic [14:0] dl_addr;
	logic ram_ack;
	logic ce_bus_p;
	logic ce_bus_n;
	logic core_reset;
	logic cpu_dtack;
	ql_bus_pkg::cpu_speed_t cpu_speed;
	ql_bus_pkg::ram_cfg_t   ram_cfg_sel;
	ql_bus_pkg::ql_word_t   dl_data;
	ql_bus_pkg::cpu_req_t   cpu_req;
	ql_bus_pkg::ql_word_t   ram_rdata;
	ql_bus_pkg::ql_word_t   cpu_rdata;
	ql_bus_pkg::ram_req_t   ram_req;

	// Reference contents
	ql_bus_pkg::ql_word_t os_ref [ROM_WORDS];
	ql_bus_pkg::ql_word_t boot_ref [ROM_WORDS];
	ql_bus_pkg::ql_word_t ram_mem [ql_bus_pkg::ql_waddr_t];
	logic  shadow_model;
	int    mismatches = 0;
	int    failures = 0;
	string test_name;

	tb_clock_gen #(.PERIOD_NS(8.0)) i_clock_gen (.clk(clk_sys));

	ql_bus_top #(.RESET_HOLD(RESET_HOLD)) i_ql_bus_top (
		.reset, .clk_sys, .cpu_speed, .ram_cfg_sel, .dl_active, .dl_index,
		.dl_wr, .dl_addr, .dl_data, .cpu_req, .ram_rdata, .ram_ack,
		.ce_bus_p, .ce_bus_n, .core_reset, .cpu_rdata, .cpu_dtack, .ram_req
	);

	// ========================================
	// Data patterns and reference model
	// ========================================
	function automatic ql_bus_pkg::ql_word_t ram_word(input ql_bus_pkg::ql_waddr_t wa);
		if (ram_mem.exists(wa))
			return ram_mem[wa];
		return wa[15:0] ^ {wa[8:0], wa[22:16]} ^ 16'h6b2d;   // Untouched RAM
	endfunction

	function automatic ql_bus_pkg::ql_word_t dl_word(input logic idx, input logic [14:0] i);
		return {i[7:0], i[14:7]} ^ (idx ? 16'hc35a : 16'h1e87);
	endfunction

	// Data source 0 zero, 1 ffff, 2 OS ROM, 3 boot ROM, 4 RAM
	function automatic void model_access(input ql_bus_pkg::ql_addr_t addr,
			input logic [1:0] strb, input ql_bus_pkg::ram_cfg_t cfg, input logic shadow,
			input logic rd, output ql_bus_pkg::ql_addr_t a, output int src,
			output logic ram_route, output logic rom_route);
		logic gc, rom, ext, os, io, ram, bcopy, ocopy;
		ql_bus_pkg::ql_addr_t mask;
		mask  = (cfg == 2'd0) ? 24'h03ffff : (cfg == 2'd3) ? 24'h7fffff : 24'h0fffff;
		a     = {addr[23:1], strb == 2'b01} & mask;
		gc    = (cfg == 2'd3);
		rom   = a < 24'h010000;
		ext   = rom && a >= 24'h00c000;
		os    = rom && !ext;
		io    = a >= 24'h018000 && a < 24'h01c000;
		bcopy = gc && a >= 24'h040000 && a < 24'h050000;
		ocopy = gc && a >= 24'h400000 && a < 24'h410000;
		ram   = (a >= 24'h020000 && a < 24'h040000)
			|| (cfg == 2'd1 && a >= 24'h040000 && a < 24'h0c0000)
			|| (cfg == 2'd2 && a >= 24'h040000 && a < 24'h100000)
			|| (gc && a >= 24'h040000 && a < 24'h400000)
			|| (gc && a >= 24'h010000 && a < 24'h018000)
			|| (gc && a >= 24'h01c100 && a < 24'h020000);
		ram_route = ram || (os && (rd ? shadow : !shadow));   // Shadow RAM path
		rom_route = rd && (rom || ocopy) && !ram_route;
		if (io)
			src = 0;
		else if (!gc)
			src = rom ? 2 : ram ? 4 : 1;
		else if (!shadow)
			src = (rom || bcopy) ? 3 : ocopy ? 2 : ram ? 4 : 1;
		else
			src = os ? 4 : (ext || ocopy) ? 2 : ram ? 4 : 1;
	endfunction

	function automatic ql_bus_pkg::ql_addr_t pick_addr();
		logic [31:0] r;
		r = $urandom;
		case ($urandom_range(0, 9))
			0: return {8'h00, r[15:0]};                    // ROM
			1: return 24'h018000 + 24'(r[13:0]);           // Internal I/O
			2: return 24'h020000 + 24'(r[16:0]);           // Base RAM
			3: return 24'h040000 + 24'(r[19:0]);
			4: return 24'h01c000 + 24'(r[7:0]);            // GoldCard I/O
			5: return 24'h010000 + 24'(r[15:0]);
			6: return 24'h400000 + 24'(r[15:0]);           // OS copy
			7: return 24'h01c000 + 24'(r[13:0]);
			8: return 24'h0c0000 + 24'(r[17:0]);           // Wrap aliases
			default: return r[23:0];
		endcase
	endfunction

	// ========================================
	// Bus master with RAM responder
	// ========================================
	task automatic do_access(input ql_bus_pkg::ql_addr_t addr, input logic rd,
			input logic [1:0] strb, input ql_bus_pkg::ql_word_t wdata);
		ql_bus_pkg::ql_addr_t a;
		ql_bus_pkg::ql_word_t exp_data;
		ql_bus_pkg::ql_word_t got;
		ql_bus_pkg::ql_word_t old;
		ql_bus_pkg::ram_req_t seen;
		int src;
		int cycles;
		int ack_cyc;
		int exp_cyc;
		int wait_cnt;
		logic ram_route, rom_route, done, acked, ack_now;
		model_access(addr, strb, ram_cfg_sel, shadow_model, rd, a, src, ram_route, rom_route);
		case (src)
			0: exp_data = 16'h0000;
			2: exp_data = os_ref[a[15:1]];
			3: exp_data = boot_ref[a[15:1]];
			4: exp_data = ram_word(a[23:1]);
			default: exp_data = 16'hffff;
		endcase
		cpu_req.waddr = addr[23:1];
		cpu_req.rw    = rd;
		cpu_req.uds   = strb[1];
		cpu_req.lds   = strb[0];
		cpu_req.wdata = wdata;
		cpu_req.as    = 1'b1;
		wait_cnt = $urandom_range(1, 4);
		cycles = 0;
		ack_cyc = -1;
		done = 1'b0;
		acked = 1'b0;
		while (!done && cycles < 50) begin
			#1;
			ack_now = 1'b0;
			if (cpu_dtack) begin
				done = 1'b1;
			end else begin
				if ((ram_req.we || ram_req.oe) && !acked) begin
					if (wait_cnt == 0) begin
						ram_ack   = 1'b1;        // Final RAM cycle
						ram_rdata = ram_word(ram_req.waddr);
						acked     = 1'b1;
						ack_now   = 1'b1;
						ack_cyc   = cycles;
					end else begin
						wait_cnt--;
					end
				end
				if (!ack_now) begin
					@(posedge clk_sys);
					cycles++;
				end
			end
		end
		seen = ram_req;
		got  = cpu_rdata;
		@(posedge clk_sys);                  // Access ends here
		if (done && ram_route && !rd) begin
			old = ram_word(a[23:1]);
			ram_mem[a[23:1]] = {strb[1] ? wdata[15:8] : old[15:8],
				strb[0] ? wdata[7:0] : old[7:0]};
		end
		#1;
		cpu_req.as = 1'b0;
		ram_ack    = 1'b0;
		ram_rdata  = '0;
		exp_cyc    = ram_route ? ack_cyc : (rom_route ? 1 : 0);
		if (!done) begin
			failures++;
			$display("No dtack for access to %h in %s", addr, test_name);
		end else begin
			assert (!rd || got == exp_data) else begin
				mismatches++;
				$display("Mismatch %s rdata @%h: expected %h, actual %h",
					test_name, a, exp_data, got);
			end
			assert ((seen.we || seen.oe) == ram_route) else begin
				mismatches++;
				$display("Mismatch %s ram route @%h: expected %b, actual %b",
					test_name, a, ram_route, seen.we || seen.oe);
			end
			assert (!ram_route || (seen.waddr == a[23:1] && {seen.uds, seen.lds} == strb
					&& (rd || seen.wdata == wdata))) else begin
				mismatches++;
				$display("Mismatch %s ram request @%h: expected %h/%b/%h, actual %h/%b/%h",
					test_name, a, a[23:1], strb, wdata, seen.waddr,
					{seen.uds, seen.lds}, seen.wdata);
			end
			assert (cycles == exp_cyc) else begin
				mismatches++;
				$display("Mismatch %s latency @%h: expected %0d, actual %0d",
					test_name, a, exp_cyc, cycles);
			end
		end
		// GoldCard shadow register follows upper byte writes
		if (!rd && ram_cfg_sel == 2'd3 && a >= 24'h01c000 && a < 24'h01c100
				&& strb == 2'b10) begin
			if (a[7:0] == 8'h60)
				shadow_model = 1'b1;
			else if (a[7:0] == 8'h64)
				shadow_model = 1'b0;
		end
		@(posedge clk_sys);
		#1;
	endtask

	// ========================================
	// Clock enables and reset
	// ========================================
	task automatic check_enables(input ql_bus_pkg::cpu_speed_t sp, input int div);
		int t, tp, tn;
		cpu_speed = sp;
		test_name = $sformatf("enables_div%0d", div);
		repeat (24) @(posedge clk_sys);
		#1;
		t = 0;
		tp = -1;
		tn = -1;
		while (t < 60) begin
			if (ce_bus_p) begin
				if (tp < 0)
					tp = t;
				else
					break;
			end
			if (ce_bus_n && tp >= 0 && tn < 0)
				tn = t;
			@(posedge clk_sys);
			#1;
			t++;
		end
		assert (t - tp == div) else begin
			mismatches++;
			$display("Mismatch %s p spacing: expected %0d, actual %0d", test_name, div, t - tp);
		end
		assert (tn - tp == div / 2) else begin
			mismatches++;
			$display("Mismatch %s n offset: expected %0d, actual %0d",
				test_name, div / 2, tn - tp);
		end
	endtask

	task automatic restart_core(input ql_bus_pkg::ram_cfg_t cfg, input logic load_roms);
		int pulses, guard;
		ram_cfg_sel = cfg;
		dl_active = 1'b1;
		@(posedge clk_sys);
		#1;
		assert (core_reset) else begin
			failures++;
			$display("core_reset did not rise while download was active");
		end
		if (load_roms) begin
			for (int idx = 0; idx < 2; idx++) begin
				for (int i = 0; i < ROM_WORDS; i++) begin
					dl_index = idx[0];
					dl_wr    = 1'b1;
					dl_addr  = i[14:0];
					dl_data  = dl_word(idx[0], i[14:0]);
					@(posedge clk_sys);
					#1;
				end
			end
			dl_wr = 1'b0;
		end
		@(posedge clk_sys);
		#1;
		dl_active = 1'b0;
		shadow_model = 1'b0;
		pulses = 0;
		guard = 0;
		while (core_reset && guard < RESET_HOLD * 12 + 8) begin
			if (ce_bus_p)
				pulses++;
			@(posedge clk_sys);
			#1;
			guard++;
		end
		assert (!core_reset && pulses == RESET_HOLD) else begin
			mismatches++;
			$display("Mismatch reset_release: expected %0d, actual %0d", RESET_HOLD, pulses);
		end
	endtask

	task automatic run_goldcard_directed();
		test_name = "gc_boot";
		do_access(24'h000100, 1'b0, 2'b11, 16'hbeef);   // Lands in RAM
		do_access(24'h000102, 1'b0, 2'b10, 16'h5a00);
		do_access(24'h000100, 1'b1, 2'b11, 16'h0);
		do_access(24'h00c010, 1'b1, 2'b11, 16'h0);
		do_access(24'h040100, 1'b1, 2'b11, 16'h0);
		do_access(24'h400100, 1'b1, 2'b11, 16'h0);
		do_access(24'h40c010, 1'b1, 2'b11, 16'h0);
		test_name = "gc_shadow";
		do_access(24'h01c060, 1'b0, 2'b10, 16'h0100);   // Shadow on
		do_access(24'h000100, 1'b1, 2'b11, 16'h0);
		do_access(24'h000102, 1'b1, 2'b11, 16'h0);
		do_access(24'h00c010, 1'b1, 2'b11, 16'h0);
		do_access(24'h400100, 1'b1, 2'b11, 16'h0);
		do_access(24'h000104, 1'b0, 2'b11, 16'h1234);
		do_access(24'h01c064, 1'b0, 2'b10, 16'h0100);   // Shadow off
		do_access(24'h000100, 1'b1, 2'b11, 16'h0);
		do_access(24'h000104, 1'b1, 2'b11, 16'h0);
	endtask

	// ========================================
	// Main sequence
	// ========================================
	initial begin
		logic [31:0] r;
		logic [1:0]  strb;
		ql_bus_pkg::ql_word_t w;
		void'($urandom(32'hd3e6_0ffb));
		reset       = 1'b1;
		cpu_speed   = ql_bus_pkg::FULL;
		ram_cfg_sel = '0;
		dl_active   = 1'b0;
		dl_index    = 1'b0;
		dl_wr       = 1'b0;
		dl_addr     = '0;
		dl_data     = '0;
		cpu_req     = '0;
		ram_rdata   = '0;
		ram_ack     = 1'b0;
		shadow_model = 1'b0;
		for (int i = 0; i < ROM_WORDS; i++) begin
			w = dl_word(1'b0, i[14:0]);
			os_ref[i] = {w[7:0], w[15:8]};
			w = dl_word(1'b1, i[14:0]);
			boot_ref[i] = {w[7:0], w[15:8]};
		end
		repeat (8) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		check_enables(ql_bus_pkg::QL, 11);
		check_enables(ql_bus_pkg::GC16, 5);
		check_enables(ql_bus_pkg::GC24, 3);
		check_enables(ql_bus_pkg::FULL, 2);
		restart_core(2'd0, 1'b1);
		for (int cfg = 0; cfg < 4; cfg++) begin
			if (cfg > 0)
				restart_core(cfg[1:0], 1'b0);
			if (cfg == 3)
				run_goldcard_directed();
			test_name = $sformatf("random_cfg%0d", cfg);
			for (int n = 0; n < NUM_RAND; n++) begin
				r = $urandom;
				strb = (r[0] || r[2:1] == 2'b00) ? 2'b11 : r[2:1];
				do_access(pick_addr(), r[0], strb, 16'($urandom));
			end
		end
		$display("Checks done: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_CYC * 8);
		$display("Watchdog expired before the tests completed");
		$display("=== FAIL ===");
		$finish;
	end

endmodule
